// File: Bender.yml
package:
  name: rv_core

sources:
  - hdl/rv_pkg.sv
  - hdl/rv_decoder.sv
  - hdl/rv_alu.sv
  - hdl/rv_register_file.sv
  - hdl/rv_store_lanes.sv
  - hdl/rv_core.sv
  - target: test
    files:
      - verification/core_properties.sv
      - verification/tb_core.sv

// File: hdl/rv_alu.sv
module rv_alu (
    input  rv_pkg::alu_op_e op,
    input  rv_pkg::word_t   lhs,
    input  rv_pkg::word_t   rhs,
    output rv_pkg::word_t   res
);

    localparam int pad = rv_pkg::xlen - 1;

    logic [4:0] shamt;

    assign shamt = rhs[4:0];

    always_comb begin
        case (op)
            rv_pkg::alu_add: res = lhs + rhs;
            rv_pkg::alu_sub: res = lhs - rhs;
            rv_pkg::alu_sll: res = lhs << shamt;
            rv_pkg::alu_xor: res = lhs ^ rhs;
            rv_pkg::alu_srl: res = lhs >> shamt;
            rv_pkg::alu_sra: res = $signed(lhs) >>> shamt;
            rv_pkg::alu_or:  res = lhs | rhs;
            rv_pkg::alu_and: res = lhs & rhs;
            // comparisons leave the flag in bit zero
            rv_pkg::alu_lt:  res = {{pad{1'b0}}, $signed(lhs) < $signed(rhs)};
            rv_pkg::alu_ltu: res = {{pad{1'b0}}, lhs < rhs};
            rv_pkg::alu_eq:  res = {{pad{1'b0}}, lhs == rhs};
            rv_pkg::alu_ne:  res = {{pad{1'b0}}, lhs != rhs};
            rv_pkg::alu_ge:  res = {{pad{1'b0}}, $signed(lhs) >= $signed(rhs)};
            rv_pkg::alu_geu: res = {{pad{1'b0}}, lhs >= rhs};
            default:         res = '0;
        endcase
    end

endmodule

// File: hdl/rv_core.sv
module rv_core #(
    parameter rv_pkg::word_t reset_pc = 32'h1000_0000
) (
    input  logic          clk,
    input  logic          reset_n,
    input  logic          ready,
    input  rv_pkg::word_t read_data,
    input  logic          read_data_valid,
    output rv_pkg::word_t addr,
    output rv_pkg::word_t write_data,
    output logic [3:0]    byte_enable,
    output logic          write_req,
    output logic          read_req
);

    typedef enum logic [2:0] {
        st_fetch_setup,
        st_fetch,
        st_decode,
        st_mem_access,
        st_writeback,
        st_error
    } state_e;

    state_e state;
    state_e state_next;

    rv_pkg::word_t pc;
    rv_pkg::word_t pc_next;
    rv_pkg::word_t pc_plus4;
    rv_pkg::word_t target_pc;

    rv_pkg::word_t addr_next;
    logic [3:0]    byte_enable_next;
    logic          write_req_next;
    logic          read_req_next;

    rv_pkg::word_t     instruction;
    logic              instr_capture;
    rv_pkg::reg_addr_t rs1;
    rv_pkg::reg_addr_t rs2;
    rv_pkg::word_t     rs1_value;
    rv_pkg::word_t     rs2_value;
    rv_pkg::decoded_t  decoded;
    rv_pkg::decoded_t  dec_q;

    rv_pkg::word_t        alu_res;
    rv_pkg::store_lanes_t lanes;

    logic          rd_write_en;
    rv_pkg::word_t rd_value;

    rv_decoder decoder0 (
        .instruction(instruction),
        .pc(pc),
        .rs1_value(rs1_value),
        .rs2_value(rs2_value),
        .rs1(rs1),
        .rs2(rs2),
        .decoded(decoded)
    );

    rv_register_file register_file0 (
        .clk(clk),
        .reset_n(reset_n),
        .rs1(rs1),
        .rs2(rs2),
        .write_en(rd_write_en),
        .rd(dec_q.rd),
        .write_value(rd_value),
        .rs1_value(rs1_value),
        .rs2_value(rs2_value)
    );

    rv_alu alu0 (
        .op(dec_q.alu_op),
        .lhs(dec_q.lhs),
        .rhs(dec_q.rhs),
        .res(alu_res)
    );

    rv_store_lanes store_lanes0 (
        .address_low(alu_res[1:0]),
        .width(dec_q.width),
        .value(dec_q.store_value),
        .lanes(lanes)
    );

    assign pc_plus4 = pc + 32'h4;

    // data may come back in the same cycle the read is accepted
    assign instr_capture = (state == st_fetch) && read_data_valid && (!read_req || ready);

    always_comb begin
        case (dec_q.kind)
            rv_pkg::kind_jal:    target_pc = alu_res;
            rv_pkg::kind_jalr:   target_pc = {alu_res[31:1], 1'b0};
            rv_pkg::kind_branch: target_pc = alu_res[0] ? pc + dec_q.branch_offset : pc_plus4;
            default:             target_pc = pc_plus4;
        endcase
    end

    assign rd_write_en = (state == st_writeback) && ready &&
                         (dec_q.kind == rv_pkg::kind_alu || dec_q.kind == rv_pkg::kind_jal ||
                          dec_q.kind == rv_pkg::kind_jalr);
    assign rd_value = (dec_q.kind == rv_pkg::kind_alu) ? alu_res : pc_plus4;

    always_comb begin
        state_next = state;
        pc_next = pc;
        addr_next = addr;
        byte_enable_next = byte_enable;
        write_req_next = write_req;
        read_req_next = read_req;

        case (state)
            st_fetch_setup: begin
                addr_next = pc;
                byte_enable_next = 4'hf;
                read_req_next = 1'b1;
                state_next = st_fetch;
            end
            st_fetch: begin
                if (read_req && ready) begin
                    read_req_next = 1'b0;
                end
                if (instr_capture) begin
                    state_next = st_decode;
                end
            end
            st_decode: begin
                case (decoded.kind)
                    rv_pkg::kind_illegal: state_next = st_error;
                    rv_pkg::kind_store:   state_next = st_mem_access;
                    default:              state_next = st_writeback;
                endcase
            end
            st_mem_access: begin
                if (lanes.crossing) begin
                    state_next = st_error;
                end else begin
                    addr_next = {alu_res[31:2], 2'b00};
                    byte_enable_next = lanes.byte_enable;
                    write_req_next = 1'b1;
                    state_next = st_writeback;
                end
            end
            st_writeback: begin
                if (ready) begin
                    write_req_next = 1'b0;
                    if (target_pc[1:0] != 2'b00) begin
                        // misaligned pc
                        state_next = st_error;
                    end else begin
                        pc_next = target_pc;
                        addr_next = target_pc;
                        byte_enable_next = 4'hf;
                        read_req_next = 1'b1;
                        state_next = st_fetch;
                    end
                end
            end
            st_error: begin
                read_req_next = 1'b0;
                write_req_next = 1'b0;
            end
            default: begin
                state_next = st_error;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= st_fetch_setup;
            pc <= reset_pc;
            addr <= '0;
            byte_enable <= '0;
            write_req <= 1'b0;
            read_req <= 1'b0;
        end else begin
            state <= state_next;
            pc <= pc_next;
            addr <= addr_next;
            byte_enable <= byte_enable_next;
            write_req <= write_req_next;
            read_req <= read_req_next;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_capture) begin
            instruction <= read_data;
        end
        if (state == st_decode) begin
            dec_q <= decoded;
        end
        if (state == st_mem_access) begin
            write_data <= lanes.data;
        end
    end

endmodule

// File: hdl/rv_decoder.sv
module rv_decoder (
    input  rv_pkg::word_t     instruction,
    input  rv_pkg::word_t     pc,
    input  rv_pkg::word_t     rs1_value,
    input  rv_pkg::word_t     rs2_value,
    output rv_pkg::reg_addr_t rs1,
    output rv_pkg::reg_addr_t rs2,
    output rv_pkg::decoded_t  decoded
);

    rv_pkg::opcode_t opcode;
    rv_pkg::funct3_t funct3;
    rv_pkg::word_t   i_immediate;
    rv_pkg::word_t   s_immediate;
    rv_pkg::word_t   u_immediate;
    rv_pkg::word_t   j_offset;
    rv_pkg::word_t   b_offset;
    rv_pkg::word_t   shift_amount;
    rv_pkg::alu_op_e funct3_op;

    assign opcode = instruction[6:0];
    assign funct3 = instruction[14:12];
    assign rs1 = instruction[19:15];
    assign rs2 = instruction[24:20];

    assign i_immediate = {{20{instruction[31]}}, instruction[31:20]};
    assign s_immediate = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign u_immediate = {instruction[31:12], 12'h000};
    assign j_offset = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                       instruction[20], instruction[30:21], 1'b0};
    assign b_offset = {{19{instruction[31]}}, instruction[31], instruction[7],
                       instruction[30:25], instruction[11:8], 1'b0};
    // immediate shifts carry shamt in the rs2 field
    assign shift_amount = {{(rv_pkg::xlen-5){1'b0}}, rs2};

    always_comb begin
        case (funct3)
            // bit 30 means sub only for register ops, for op_imm it is immediate
            rv_pkg::f3_add:  funct3_op = (opcode == rv_pkg::opcode_op && instruction[30]) ?
                                         rv_pkg::alu_sub : rv_pkg::alu_add;
            rv_pkg::f3_sll:  funct3_op = rv_pkg::alu_sll;
            rv_pkg::f3_slt:  funct3_op = rv_pkg::alu_lt;
            rv_pkg::f3_sltu: funct3_op = rv_pkg::alu_ltu;
            rv_pkg::f3_xor:  funct3_op = rv_pkg::alu_xor;
            rv_pkg::f3_srl:  funct3_op = instruction[30] ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            rv_pkg::f3_or:   funct3_op = rv_pkg::alu_or;
            default:         funct3_op = rv_pkg::alu_and;
        endcase
    end

    always_comb begin
        decoded.alu_op = funct3_op;
        decoded.lhs = rs1_value;
        decoded.rhs = rs2_value;
        decoded.kind = rv_pkg::kind_alu;
        decoded.rd = instruction[11:7];
        decoded.branch_offset = b_offset;
        decoded.width = funct3;
        decoded.store_value = rs2_value;

        case (opcode)
            rv_pkg::opcode_lui: begin
                decoded.alu_op = rv_pkg::alu_add;
                decoded.lhs = u_immediate;
                decoded.rhs = '0;
            end
            rv_pkg::opcode_auipc: begin
                decoded.alu_op = rv_pkg::alu_add;
                decoded.lhs = u_immediate;
                decoded.rhs = pc;
            end
            rv_pkg::opcode_jal: begin
                decoded.kind = rv_pkg::kind_jal;
                decoded.alu_op = rv_pkg::alu_add;
                decoded.lhs = j_offset;
                decoded.rhs = pc;
            end
            rv_pkg::opcode_jalr: begin
                decoded.kind = rv_pkg::kind_jalr;
                decoded.alu_op = rv_pkg::alu_add;
                decoded.rhs = i_immediate;
            end
            rv_pkg::opcode_branch: begin
                decoded.kind = rv_pkg::kind_branch;
                case (funct3)
                    rv_pkg::f3_beq:  decoded.alu_op = rv_pkg::alu_eq;
                    rv_pkg::f3_bne:  decoded.alu_op = rv_pkg::alu_ne;
                    rv_pkg::f3_blt:  decoded.alu_op = rv_pkg::alu_lt;
                    rv_pkg::f3_bge:  decoded.alu_op = rv_pkg::alu_ge;
                    rv_pkg::f3_bltu: decoded.alu_op = rv_pkg::alu_ltu;
                    rv_pkg::f3_bgeu: decoded.alu_op = rv_pkg::alu_geu;
                    default:         decoded.kind = rv_pkg::kind_illegal;
                endcase
            end
            rv_pkg::opcode_store: begin
                decoded.kind = rv_pkg::kind_store;
                decoded.alu_op = rv_pkg::alu_add;
                decoded.rhs = s_immediate;
                if (funct3 != rv_pkg::f3_sb && funct3 != rv_pkg::f3_sh &&
                    funct3 != rv_pkg::f3_sw) begin
                    decoded.kind = rv_pkg::kind_illegal;
                end
            end
            rv_pkg::opcode_op_imm: begin
                decoded.rhs = (funct3 == rv_pkg::f3_sll || funct3 == rv_pkg::f3_srl) ?
                              shift_amount : i_immediate;
            end
            rv_pkg::opcode_op: begin
                // register operands already in place
            end
            rv_pkg::opcode_fence: begin
                decoded.kind = rv_pkg::kind_nop;
            end
            rv_pkg::opcode_system: begin
                // csr forms are not supported
                decoded.kind = (funct3 == rv_pkg::f3_priv) ?
                               rv_pkg::kind_nop : rv_pkg::kind_illegal;
            end
            default: begin
                decoded.kind = rv_pkg::kind_illegal;
            end
        endcase
    end

endmodule

// File: hdl/rv_pkg.sv
package rv_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0] reg_addr_t;
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;

    // base opcodes
    localparam opcode_t opcode_lui    = 7'b0110111;
    localparam opcode_t opcode_auipc  = 7'b0010111;
    localparam opcode_t opcode_jal    = 7'b1101111;
    localparam opcode_t opcode_jalr   = 7'b1100111;
    localparam opcode_t opcode_branch = 7'b1100011;
    localparam opcode_t opcode_store  = 7'b0100011;
    localparam opcode_t opcode_op_imm = 7'b0010011;
    localparam opcode_t opcode_op     = 7'b0110011;
    localparam opcode_t opcode_fence  = 7'b0001111;
    localparam opcode_t opcode_system = 7'b1110011;

    // alu funct3
    localparam funct3_t f3_add  = 3'b000;
    localparam funct3_t f3_sll  = 3'b001;
    localparam funct3_t f3_slt  = 3'b010;
    localparam funct3_t f3_sltu = 3'b011;
    localparam funct3_t f3_xor  = 3'b100;
    localparam funct3_t f3_srl  = 3'b101;
    localparam funct3_t f3_or   = 3'b110;
    localparam funct3_t f3_and  = 3'b111;

    // branch funct3
    localparam funct3_t f3_beq  = 3'b000;
    localparam funct3_t f3_bne  = 3'b001;
    localparam funct3_t f3_blt  = 3'b100;
    localparam funct3_t f3_bge  = 3'b101;
    localparam funct3_t f3_bltu = 3'b110;
    localparam funct3_t f3_bgeu = 3'b111;

    // store widths
    localparam funct3_t f3_sb = 3'b000;
    localparam funct3_t f3_sh = 3'b001;
    localparam funct3_t f3_sw = 3'b010;

    // ecall, ebreak
    localparam funct3_t f3_priv = 3'b000;

    localparam int alu_op_count = 14;

    typedef enum logic [$clog2(alu_op_count)-1:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_lt,
        alu_ltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_eq,
        alu_ne,
        alu_ge,
        alu_geu
    } alu_op_e;

    typedef enum logic [2:0] {
        kind_alu,
        kind_jal,
        kind_jalr,
        kind_branch,
        kind_store,
        kind_nop,
        kind_illegal
    } instr_kind_e;

    typedef struct packed {
        alu_op_e     alu_op;
        word_t       lhs;
        word_t       rhs;
        instr_kind_e kind;
        reg_addr_t   rd;
        word_t       branch_offset;
        funct3_t     width;
        word_t       store_value;
    } decoded_t;

    typedef struct packed {
        word_t               data;
        logic [xlen/8-1:0]   byte_enable;
        logic                crossing;
    } store_lanes_t;

endpackage

// File: hdl/rv_register_file.sv
module rv_register_file (
    input  logic              clk,
    input  logic              reset_n,
    input  rv_pkg::reg_addr_t rs1,
    input  rv_pkg::reg_addr_t rs2,
    input  logic              write_en,
    input  rv_pkg::reg_addr_t rd,
    input  rv_pkg::word_t     write_value,
    output rv_pkg::word_t     rs1_value,
    output rv_pkg::word_t     rs2_value
);

    // x0 has no storage
    rv_pkg::word_t regs [1:31];

    assign rs1_value = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_value = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && rd != '0) begin
            regs[rd] <= write_value;
        end
    end

endmodule

// File: hdl/rv_store_lanes.sv
module rv_store_lanes (
    input  logic [1:0]           address_low,
    input  rv_pkg::funct3_t      width,
    input  rv_pkg::word_t        value,
    output rv_pkg::store_lanes_t lanes
);

    logic [4:0] bit_offset;

    assign bit_offset = {address_low, 3'b000};

    always_comb begin
        lanes.data = '0;
        lanes.byte_enable = '0;
        lanes.crossing = 1'b0;

        case (width)
            rv_pkg::f3_sb: begin
                lanes.data = {24'h0, value[7:0]} << bit_offset;
                lanes.byte_enable = 4'b0001 << address_low;
            end
            rv_pkg::f3_sh: begin
                lanes.data = {16'h0, value[15:0]} << bit_offset;
                lanes.byte_enable = 4'b0011 << address_low;
                // upper byte would spill into the next word
                lanes.crossing = (address_low == 2'b11);
            end
            rv_pkg::f3_sw: begin
                lanes.data = value;
                lanes.byte_enable = 4'b1111;
                lanes.crossing = (address_low != 2'b00);
            end
            default: begin
                lanes.data = '0;
            end
        endcase
    end

endmodule

// File: verification/core_properties.sv
module core_properties (
    input logic          clk,
    input logic          reset_n,
    input logic          ready,
    input rv_pkg::word_t addr,
    input logic [3:0]    byte_enable,
    input logic          write_req,
    input logic          read_req
);

    int failures = 0;

    one_request: assert property (@(posedge clk) disable iff (!reset_n)
        !(read_req && write_req))
        else begin
            failures++;
            $error("read_req and write_req high together");
        end

    aligned_addr: assert property (@(posedge clk) disable iff (!reset_n)
        (read_req || write_req) |-> addr[1:0] == 2'b00)
        else begin
            failures++;
            $error("request with a misaligned addr");
        end

    write_lanes: assert property (@(posedge clk) disable iff (!reset_n)
        write_req |-> byte_enable != 4'b0000)
        else begin
            failures++;
            $error("write_req with no byte enabled");
        end

    // stalled request must not move
    hold_on_stall: assert property (@(posedge clk) disable iff (!reset_n)
        (read_req || write_req) && !ready |=>
            $stable(read_req) && $stable(write_req) && $stable(addr) && $stable(byte_enable))
        else begin
            failures++;
            $error("request changed while ready was low");
        end

endmodule

bind rv_core core_properties props0 (
    .clk(clk),
    .reset_n(reset_n),
    .ready(ready),
    .addr(addr),
    .byte_enable(byte_enable),
    .write_req(write_req),
    .read_req(read_req)
);

// File: verification/tb_core.sv
module tb_core;

    localparam rv_pkg::word_t reset_pc = 32'h1000_0000;

    typedef struct packed {
        rv_pkg::word_t addr;
        rv_pkg::word_t data;
        logic [3:0]    byte_enable;
    } store_t;

    logic          clk = 1'b0;
    logic          reset_n;
    logic          ready;
    rv_pkg::word_t read_data;
    logic          read_data_valid;
    rv_pkg::word_t addr;
    rv_pkg::word_t write_data;
    logic [3:0]    byte_enable;
    logic          write_req;
    logic          read_req;

    rv_pkg::word_t program_words [$];
    store_t        expected_stores [$];
    rv_pkg::word_t mem [rv_pkg::word_t];
    rv_pkg::word_t final_addr;
    int            store_index = 0;
    bit            final_fetched = 1'b0;

    rv_core #(
        .reset_pc(reset_pc)
    ) dut0 (
        .clk(clk),
        .reset_n(reset_n),
        .ready(ready),
        .read_data(read_data),
        .read_data_valid(read_data_valid),
        .addr(addr),
        .write_data(write_data),
        .byte_enable(byte_enable),
        .write_req(write_req),
        .read_req(read_req)
    );

    always #10 clk = ~clk;

    task automatic stop_with_failure();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_address(input rv_pkg::word_t actual, input rv_pkg::word_t expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: addr is %h, expected %h", $time, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic compare_write_data(input rv_pkg::word_t actual,
                                      input rv_pkg::word_t expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: write_data is %h, expected %h", $time, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic expect_byte_enable(input logic [3:0] actual, input logic [3:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: byte_enable is %b, expected %b", $time, actual, expected);
            stop_with_failure();
        end
    endtask

    // rv32i instruction formats
    function automatic rv_pkg::word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                             input rv_pkg::reg_addr_t rd,
                                             input rv_pkg::reg_addr_t rs1,
                                             input rv_pkg::reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, rv_pkg::opcode_op};
    endfunction

    function automatic rv_pkg::word_t i_type(input logic [6:0] opcode, input logic [2:0] f3,
                                             input rv_pkg::reg_addr_t rd,
                                             input rv_pkg::reg_addr_t rs1,
                                             input logic [31:0] imm);
        return {imm[11:0], rs1, f3, rd, opcode};
    endfunction

    function automatic rv_pkg::word_t s_type(input logic [2:0] f3, input rv_pkg::reg_addr_t rs2,
                                             input rv_pkg::reg_addr_t rs1,
                                             input logic [31:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_pkg::opcode_store};
    endfunction

    function automatic rv_pkg::word_t b_type(input logic [2:0] f3, input rv_pkg::reg_addr_t rs1,
                                             input rv_pkg::reg_addr_t rs2,
                                             input logic [31:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::opcode_branch};
    endfunction

    function automatic rv_pkg::word_t u_type(input logic [6:0] opcode,
                                             input rv_pkg::reg_addr_t rd,
                                             input logic [19:0] imm);
        return {imm, rd, opcode};
    endfunction

    function automatic rv_pkg::word_t j_type(input rv_pkg::reg_addr_t rd,
                                             input logic [31:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::opcode_jal};
    endfunction

    task automatic build_program();
        // x10 is the store base, x1 = -7, x2 = 3
        program_words.push_back(u_type(rv_pkg::opcode_lui, 10, 20'h20000));
        program_words.push_back(i_type(rv_pkg::opcode_op_imm, 3'b000, 1, 0, -7));
        program_words.push_back(i_type(rv_pkg::opcode_op_imm, 3'b000, 2, 0, 3));
        program_words.push_back(r_type(7'h20, 3'b000, 3, 1, 2));
        program_words.push_back(s_type(3'b010, 3, 10, 0));
        program_words.push_back(r_type(7'h20, 3'b101, 4, 1, 2));
        program_words.push_back(s_type(3'b010, 4, 10, 4));
        program_words.push_back(i_type(rv_pkg::opcode_op_imm, 3'b101, 5, 1, 4));
        program_words.push_back(s_type(3'b010, 5, 10, 8));
        program_words.push_back(i_type(rv_pkg::opcode_op_imm, 3'b001, 6, 2, 5));
        program_words.push_back(s_type(3'b010, 6, 10, 12));
        program_words.push_back(r_type(7'h00, 3'b010, 7, 1, 2));
        program_words.push_back(s_type(3'b010, 7, 10, 16));
        program_words.push_back(r_type(7'h00, 3'b011, 8, 1, 2));
        program_words.push_back(s_type(3'b010, 8, 10, 20));
        program_words.push_back(r_type(7'h00, 3'b100, 11, 1, 2));
        program_words.push_back(i_type(rv_pkg::opcode_op_imm, 3'b111, 12, 11, 32'h3c));
        program_words.push_back(s_type(3'b010, 12, 10, 24));
        program_words.push_back(u_type(rv_pkg::opcode_auipc, 13, 20'h00001));
        program_words.push_back(s_type(3'b010, 13, 10, 28));
        program_words.push_back(u_type(rv_pkg::opcode_lui, 14, 20'ha1b2c));
        program_words.push_back(i_type(rv_pkg::opcode_op_imm, 3'b000, 14, 14, 32'h3d4));
        for (int i = 0; i < 4; i++) begin
            program_words.push_back(s_type(3'b000, 14, 10, 32 + i));
        end
        for (int i = 0; i < 3; i++) begin
            program_words.push_back(s_type(3'b001, 14, 10, 36 + i));
        end
        // each branch is taken over an illegal word, then not taken before a store
        for (int i = 0; i < 6; i++) begin
            logic [2:0] f3;
            f3 = (i < 2) ? i[2:0] : i[2:0] + 3'd2;
            if (f3 == 3'b000 || f3 == 3'b001) begin
                program_words.push_back(b_type(f3, f3 == 3'b000 ? 7 : 1, f3 == 3'b000 ? 7 : 2, 8));
                program_words.push_back(32'h0);
                program_words.push_back(b_type(f3, f3 == 3'b000 ? 1 : 7, f3 == 3'b000 ? 2 : 7, 8));
            end else begin
                // signed and unsigned forms need the operands in opposite order
                program_words.push_back(b_type(f3, f3[0] ^ f3[1] ? 2 : 1, f3[0] ^ f3[1] ? 1 : 2, 8));
                program_words.push_back(32'h0);
                program_words.push_back(b_type(f3, f3[0] ^ f3[1] ? 1 : 2, f3[0] ^ f3[1] ? 2 : 1, 8));
            end
            program_words.push_back(s_type(3'b010, 2, 10, 40 + 4 * i));
        end
        program_words.push_back(j_type(16, 8));
        program_words.push_back(32'h0);
        program_words.push_back(s_type(3'b010, 16, 10, 64));
        program_words.push_back(u_type(rv_pkg::opcode_auipc, 17, 20'h00000));
        program_words.push_back(i_type(rv_pkg::opcode_jalr, 3'b000, 18, 17, 13));
        program_words.push_back(32'h0);
        program_words.push_back(s_type(3'b010, 18, 10, 68));
        // sw to an odd address stops the core
        program_words.push_back(s_type(3'b010, 2, 10, 1));

        expected_stores.push_back('{32'h2000_0000, 32'hffff_fff6, 4'hf});
        expected_stores.push_back('{32'h2000_0004, 32'hffff_ffff, 4'hf});
        expected_stores.push_back('{32'h2000_0008, 32'h0fff_ffff, 4'hf});
        expected_stores.push_back('{32'h2000_000c, 32'h0000_0060, 4'hf});
        expected_stores.push_back('{32'h2000_0010, 32'h0000_0001, 4'hf});
        expected_stores.push_back('{32'h2000_0014, 32'h0000_0000, 4'hf});
        expected_stores.push_back('{32'h2000_0018, 32'h0000_0038, 4'hf});
        expected_stores.push_back('{32'h2000_001c, 32'h1000_1048, 4'hf});
        expected_stores.push_back('{32'h2000_0020, 32'h0000_00d4, 4'h1});
        expected_stores.push_back('{32'h2000_0020, 32'h0000_d400, 4'h2});
        expected_stores.push_back('{32'h2000_0020, 32'h00d4_0000, 4'h4});
        expected_stores.push_back('{32'h2000_0020, 32'hd400_0000, 4'h8});
        expected_stores.push_back('{32'h2000_0024, 32'h0000_c3d4, 4'h3});
        expected_stores.push_back('{32'h2000_0024, 32'h00c3_d400, 4'h6});
        expected_stores.push_back('{32'h2000_0024, 32'hc3d4_0000, 4'hc});
        for (int i = 0; i < 6; i++) begin
            expected_stores.push_back('{32'h2000_0028 + 4 * i, 32'h0000_0003, 4'hf});
        end
        expected_stores.push_back('{32'h2000_0040, 32'h1000_00d8, 4'hf});
        expected_stores.push_back('{32'h2000_0044, 32'h1000_00e8, 4'hf});
    endtask

    // memory model drives all inputs on the falling edge
    initial begin
        logic          prev_read_req;
        logic          prev_write_req;
        rv_pkg::word_t prev_addr;
        rv_pkg::word_t prev_write_data;
        logic [3:0]    prev_byte_enable;
        rv_pkg::word_t fetch_data;
        logic          read_pending;
        int            delay;
        void'($urandom(32'hfa45));
        ready = 1'b0;
        read_data = '0;
        read_data_valid = 1'b0;
        prev_read_req = 1'b0;
        prev_write_req = 1'b0;
        prev_addr = '0;
        prev_write_data = '0;
        prev_byte_enable = '0;
        fetch_data = '0;
        read_pending = 1'b0;
        delay = 0;
        forever begin
            @(negedge clk);
            // valid was taken on the edge just passed
            read_data_valid = 1'b0;
            if (dut0.props0.failures != 0) begin
                $display("bus protocol assertion failed before %0t", $time);
                stop_with_failure();
            end
            if (prev_read_req && ready) begin
                if (!mem.exists(prev_addr)) begin
                    $display("fetch from %h lies outside the program", prev_addr);
                    stop_with_failure();
                end
                expect_byte_enable(prev_byte_enable, 4'hf);
                fetch_data = mem[prev_addr];
                read_pending = 1'b1;
                delay = $urandom_range(2, 0);
                if (prev_addr == final_addr) begin
                    final_fetched = 1'b1;
                end
            end
            if (prev_write_req && ready) begin
                if (store_index >= expected_stores.size()) begin
                    $display("write to %h after the last expected store", prev_addr);
                    stop_with_failure();
                end
                check_address(prev_addr, expected_stores[store_index].addr);
                compare_write_data(prev_write_data, expected_stores[store_index].data);
                expect_byte_enable(prev_byte_enable, expected_stores[store_index].byte_enable);
                store_index++;
            end
            if (read_pending) begin
                if (delay == 0) begin
                    read_data = fetch_data;
                    read_data_valid = 1'b1;
                    read_pending = 1'b0;
                end else begin
                    delay--;
                end
            end
            ready = ($urandom_range(3, 0) != 0);
            prev_read_req = read_req;
            prev_write_req = write_req;
            prev_addr = addr;
            prev_write_data = write_data;
            prev_byte_enable = byte_enable;
        end
    end

    initial begin
        reset_n = 1'b0;
        build_program();
        for (int i = 0; i < program_words.size(); i++) begin
            mem[reset_pc + 4 * i] = program_words[i];
        end
        final_addr = reset_pc + 4 * (program_words.size() - 1);
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        wait (store_index == expected_stores.size());
        wait (final_fetched);
        repeat (50) begin
            @(negedge clk);
            if (read_req || write_req) begin
                $display("bus request at %0t after the core should have stopped", $time);
                stop_with_failure();
            end
        end
        if (dut0.props0.failures == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("bus protocol assertions failed %0d times", dut0.props0.failures);
            stop_with_failure();
        end
    end

    // watchdog
    initial begin
        @(posedge reset_n);
        #(program_words.size() * 200 * 20);
        $display("timeout: the core did not finish the program");
        stop_with_failure();
    end

endmodule

// File: verilog.f
hdl/rv_pkg.sv
hdl/rv_decoder.sv
hdl/rv_alu.sv
hdl/rv_register_file.sv
hdl/rv_store_lanes.sv
hdl/rv_core.sv
verification/core_properties.sv
verification/tb_core.sv
